/* common/wg_params.svh */
// Width, port count, FIFO depth and debounce length macros
`ifndef WG_PARAMS_SVH
`define WG_PARAMS_SVH

// Stream byte width
`define WG_DATA_W 8

// Register word and address widths
`define WG_CSR_DATA_W 16
`define WG_CSR_ADDR_W 3

// Stream inputs into the dpe
`define WG_NUM_IN 3

// Per-input buffering, in beats and in frames
`define WG_BEAT_DEPTH 16
`define WG_ROUTE_DEPTH 4

// Cycles a key must hold before it changes state
`define WG_DEBOUNCE_CYCLES 8

`endif

/* common/dpe_pkg.sv */
// Stream beat type, frame route type and port index values
`default_nettype none
`include "wg_params.svh"

package dpe_pkg;

   typedef struct packed {
      logic [`WG_DATA_W-1:0] data;   // Payload byte
      logic                  last;   // Final beat of frame
   } beat_t;

   typedef logic [1:0] route_t;      // Frame destination

   //====================
   // Destination codes
   //====================
   localparam route_t PORT_CPU  = 2'd0;
   localparam route_t PORT_ETH1 = 2'd1;
   localparam route_t PORT_ETH2 = 2'd2;
   localparam route_t PORT_DROP = 2'd3;   // Consumed, never forwarded

endpackage

`default_nettype wire

/* common/csr_pkg.sv */
// Register address map, register word type, control layout and route table type
`default_nettype none
`include "wg_params.svh"

package csr_pkg;

   typedef logic [`WG_CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [`WG_CSR_DATA_W-1:0] csr_word_t;

   //====================
   // Address map
   //====================
   localparam csr_addr_t ADDR_CTRL     = 3'd0;   // R/W
   localparam csr_addr_t ADDR_ROUTE    = 3'd1;   // R/W
   localparam csr_addr_t ADDR_KEYS     = 3'd2;   // RO, debounced keys
   localparam csr_addr_t ADDR_CNT_CPU  = 3'd3;   // RO frame counters
   localparam csr_addr_t ADDR_CNT_ETH1 = 3'd4;
   localparam csr_addr_t ADDR_CNT_ETH2 = 3'd5;
   localparam csr_addr_t ADDR_CNT_DROP = 3'd6;

   //====================
   // Control fields
   //====================
   localparam int CTRL_ENABLE_BIT = 0;   // Forwarding enable
   localparam int CTRL_LED_LSB    = 1;   // LED value, two bits
   localparam int CTRL_LED_W      = 2;

   // One entry per header class, class taken from header bits 1:0
   typedef dpe_pkg::route_t [3:0] route_table_t;

endpackage

`default_nettype wire

/* src/stream_fifo.sv */
// First-word fall-through FIFO with a type parameter for its payload
`default_nettype none

module stream_fifo #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = 4
) (
   input  logic clk,
   input  logic rst,
   input  logic wr_valid,
   input  T     wr_data,
   output logic wr_ready,
   output logic rd_valid,
   output T     rd_data,
   input  logic rd_ready
);
   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   T                mem [DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [CW-1:0]   count;       // Occupancy
   logic            do_wr;
   logic            do_rd;

   assign wr_ready = (count != CW'(DEPTH));   // Room left
   assign rd_valid = (count != '0);
   assign rd_data  = mem[rd_ptr];             // Head always visible

   assign do_wr = wr_valid && wr_ready;
   assign do_rd = rd_valid && rd_ready;

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // Wrap
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/gpio.sv */
// Key synchronizer and debouncer, registered active-low LED drive
`default_nettype none
`include "wg_params.svh"

module gpio (
   input  logic       clk,
   input  logic       rst,
   input  logic [1:0] key_in,      // Active low pins
   output logic [1:0] key_state,   // Active high, debounced
   input  logic [1:0] led_value,
   output logic [1:0] led          // Active low pins
);
   localparam int CNT_W = $clog2(`WG_DEBOUNCE_CYCLES + 1);

   logic [1:0]       sync_q1;
   logic [1:0]       sync_q2;
   logic [CNT_W-1:0] stable_cnt [2];

   always_ff @(posedge clk) begin
      if (rst) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
         led     <= '1;                  // LEDs off
      end else begin
         sync_q1 <= ~key_in;             // Invert to active high
         sync_q2 <= sync_q1;
         led     <= ~led_value;
      end
   end

   // State follows input once it differs for the full window
   always_ff @(posedge clk) begin
      if (rst) begin
         key_state <= '0;
         for (int k = 0; k < 2; k++) begin
            stable_cnt[k] <= '0;
         end
      end else begin
         for (int k = 0; k < 2; k++) begin
            if (sync_q2[k] == key_state[k]) begin
               stable_cnt[k] <= '0;      // Glitch ended, restart
            end else if (stable_cnt[k] == CNT_W'(`WG_DEBOUNCE_CYCLES - 1)) begin
               key_state[k]  <= sync_q2[k];
               stable_cnt[k] <= '0;
            end else begin
               stable_cnt[k] <= stable_cnt[k] + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* csr/soc_csr.sv */
// Control, route table, key status and frame counter registers on a strobe bus
`default_nettype none

module soc_csr (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  csr_we,
   input  logic                  csr_re,
   input  csr_pkg::csr_addr_t    csr_addr,
   input  csr_pkg::csr_word_t    csr_wdata,
   output csr_pkg::csr_word_t    csr_rdata,
   output logic                  csr_rvalid,
   input  logic [1:0]            key_state,
   output logic [1:0]            led_value,
   output logic                  dpe_enable,
   output csr_pkg::route_table_t route_table,
   input  logic                  sent_pulse,
   input  dpe_pkg::route_t       sent_route
);
   localparam int RT_W = $bits(csr_pkg::route_table_t);

   csr_pkg::csr_word_t    ctrl;
   csr_pkg::route_table_t route;
   csr_pkg::csr_word_t    cnt [4];   // One per route code
   csr_pkg::csr_word_t    rd_word;

   //====================
   // Writable registers
   //====================
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl  <= '0;                   // Disabled, LEDs off
         route <= '0;                   // All classes to CPU
      end else if (csr_we) begin
         case (csr_addr)
            csr_pkg::ADDR_CTRL:  ctrl  <= csr_wdata;
            csr_pkg::ADDR_ROUTE: route <= csr_wdata[RT_W-1:0];
            default:             ;      // Read-only or unused
         endcase
      end
   end

   assign dpe_enable  = ctrl[csr_pkg::CTRL_ENABLE_BIT];
   assign led_value   = ctrl[csr_pkg::CTRL_LED_LSB +: csr_pkg::CTRL_LED_W];
   assign route_table = route;

   // Finished frames per destination, wrapping
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int r = 0; r < 4; r++) begin
            cnt[r] <= '0;
         end
      end else if (sent_pulse) begin
         cnt[sent_route] <= cnt[sent_route] + 1'b1;
      end
   end

   //====================
   // Read path
   //====================
   always_comb begin
      case (csr_addr)
         csr_pkg::ADDR_CTRL:     rd_word = ctrl;
         csr_pkg::ADDR_ROUTE:    rd_word = csr_pkg::csr_word_t'(route);
         csr_pkg::ADDR_KEYS:     rd_word = csr_pkg::csr_word_t'(key_state);
         csr_pkg::ADDR_CNT_CPU:  rd_word = cnt[dpe_pkg::PORT_CPU];
         csr_pkg::ADDR_CNT_ETH1: rd_word = cnt[dpe_pkg::PORT_ETH1];
         csr_pkg::ADDR_CNT_ETH2: rd_word = cnt[dpe_pkg::PORT_ETH2];
         csr_pkg::ADDR_CNT_DROP: rd_word = cnt[dpe_pkg::PORT_DROP];
         default:                rd_word = '0;   // Unmapped
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         csr_rvalid <= 1'b0;
      end else begin
         csr_rvalid <= csr_re;          // One cycle after strobe
      end
   end

   always_ff @(posedge clk) begin
      if (csr_re) begin
         csr_rdata <= rd_word;
      end
   end

endmodule

`default_nettype wire

/* dpe/dpe.sv */
// Data-plane engine with input buffering, route lookup, frame round-robin and output steering
`default_nettype none
`include "wg_params.svh"

module dpe (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [`WG_DATA_W-1:0] cpu_in_data,
   input  logic                  cpu_in_valid,
   input  logic                  cpu_in_last,
   output logic                  cpu_in_ready,
   input  logic [`WG_DATA_W-1:0] eth1_in_data,
   input  logic                  eth1_in_valid,
   input  logic                  eth1_in_last,
   output logic                  eth1_in_ready,
   input  logic [`WG_DATA_W-1:0] eth2_in_data,
   input  logic                  eth2_in_valid,
   input  logic                  eth2_in_last,
   output logic                  eth2_in_ready,
   output logic [`WG_DATA_W-1:0] cpu_out_data,
   output logic                  cpu_out_valid,
   output logic                  cpu_out_last,
   input  logic                  cpu_out_ready,
   output logic [`WG_DATA_W-1:0] eth1_out_data,
   output logic                  eth1_out_valid,
   output logic                  eth1_out_last,
   input  logic                  eth1_out_ready,
   output logic [`WG_DATA_W-1:0] eth2_out_data,
   output logic                  eth2_out_valid,
   output logic                  eth2_out_last,
   input  logic                  eth2_out_ready,
   input  logic                  dpe_enable,
   input  csr_pkg::route_table_t route_table,
   output logic                  sent_pulse,
   output dpe_pkg::route_t       sent_route
);
   localparam int NUM_IN = `WG_NUM_IN;

   logic [`WG_DATA_W-1:0] in_data [NUM_IN];
   logic [NUM_IN-1:0]     in_valid;
   logic [NUM_IN-1:0]     in_last;
   logic                  in_ready [NUM_IN];
   logic [NUM_IN-1:0]     out_ready;          // Indexed by route code

   logic                  beat_wr_ready [NUM_IN];
   logic                  beat_rd_valid [NUM_IN];
   dpe_pkg::beat_t        beat_rd       [NUM_IN];
   logic [NUM_IN-1:0]     beat_rd_ready;
   logic                  route_wr_ready [NUM_IN];
   logic                  route_rd_valid [NUM_IN];
   dpe_pkg::route_t       route_rd       [NUM_IN];
   logic [NUM_IN-1:0]     route_rd_ready;

   logic                  locked;       // Frame in progress
   logic [1:0]            sel;          // Locked input
   logic [1:0]            rr_ptr;       // First input to consider
   dpe_pkg::route_t       cur_route;
   logic                  grant_found;
   logic [1:0]            grant_idx;
   dpe_pkg::beat_t        cur_beat;
   logic                  cur_valid;
   logic                  cur_pop;

   assign in_data   = '{cpu_in_data, eth1_in_data, eth2_in_data};
   assign in_valid  = {eth2_in_valid, eth1_in_valid, cpu_in_valid};
   assign in_last   = {eth2_in_last, eth1_in_last, cpu_in_last};
   assign out_ready = {eth2_out_ready, eth1_out_ready, cpu_out_ready};

   assign cpu_in_ready  = in_ready[0];
   assign eth1_in_ready = in_ready[1];
   assign eth2_in_ready = in_ready[2];

   //====================
   // Input buffering
   //====================
   for (genvar i = 0; i < NUM_IN; i++) begin : g_in
      logic            hdr;        // Next beat opens a frame
      logic            accept;
      dpe_pkg::beat_t  beat_in;
      dpe_pkg::route_t lookup;

      assign in_ready[i] = beat_wr_ready[i] && route_wr_ready[i];
      assign accept      = in_valid[i] && in_ready[i];
      assign beat_in     = '{data: in_data[i], last: in_last[i]};
      assign lookup      = dpe_enable ? route_table[in_data[i][1:0]] : dpe_pkg::PORT_DROP;

      always_ff @(posedge clk) begin
         if (rst) begin
            hdr <= 1'b1;
         end else if (accept) begin
            hdr <= in_last[i];            // Header follows each last
         end
      end

      stream_fifo #(.T(dpe_pkg::beat_t), .DEPTH(`WG_BEAT_DEPTH)) u_beat_fifo (
         .clk      (clk),
         .rst      (rst),
         .wr_valid (accept),
         .wr_data  (beat_in),
         .wr_ready (beat_wr_ready[i]),
         .rd_valid (beat_rd_valid[i]),
         .rd_data  (beat_rd[i]),
         .rd_ready (beat_rd_ready[i])
      );

      stream_fifo #(.T(dpe_pkg::route_t), .DEPTH(`WG_ROUTE_DEPTH)) u_route_fifo (
         .clk      (clk),
         .rst      (rst),
         .wr_valid (accept && hdr),       // Route fixed at header
         .wr_data  (lookup),
         .wr_ready (route_wr_ready[i]),
         .rd_valid (route_rd_valid[i]),
         .rd_data  (route_rd[i]),
         .rd_ready (route_rd_ready[i])
      );
   end

   //====================
   // Frame arbitration
   //====================
   always_comb begin
      int unsigned cand;
      grant_found = 1'b0;
      grant_idx   = '0;
      for (int k = NUM_IN - 1; k >= 0; k--) begin     // Lowest offset wins
         cand = (rr_ptr + k) % NUM_IN;
         if (beat_rd_valid[cand] && route_rd_valid[cand]) begin
            grant_found = 1'b1;
            grant_idx   = 2'(cand);
         end
      end
   end

   assign cur_beat  = beat_rd[sel];
   assign cur_valid = locked && beat_rd_valid[sel];
   assign cur_pop   = cur_valid && (cur_route == dpe_pkg::PORT_DROP || out_ready[cur_route]);

   always_comb begin
      beat_rd_ready  = '0;
      route_rd_ready = '0;
      if (locked) begin
         beat_rd_ready[sel] = cur_pop;
      end else if (grant_found) begin
         route_rd_ready[grant_idx] = 1'b1;   // Route taken at lock
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         locked     <= 1'b0;
         sel        <= '0;
         rr_ptr     <= '0;
         sent_pulse <= 1'b0;
      end else begin
         sent_pulse <= 1'b0;
         if (!locked && grant_found) begin
            locked <= 1'b1;
            sel    <= grant_idx;
         end else if (cur_pop && cur_beat.last) begin
            locked     <= 1'b0;
            rr_ptr     <= (sel == 2'(NUM_IN - 1)) ? '0 : sel + 1'b1;
            sent_pulse <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!locked && grant_found) begin
         cur_route <= route_rd[grant_idx];
      end
      if (cur_pop && cur_beat.last) begin
         sent_route <= cur_route;
      end
   end

   //====================
   // Output steering
   //====================
   assign cpu_out_data   = cur_beat.data;
   assign eth1_out_data  = cur_beat.data;
   assign eth2_out_data  = cur_beat.data;
   assign cpu_out_last   = cur_beat.last;
   assign eth1_out_last  = cur_beat.last;
   assign eth2_out_last  = cur_beat.last;
   assign cpu_out_valid  = cur_valid && (cur_route == dpe_pkg::PORT_CPU);
   assign eth1_out_valid = cur_valid && (cur_route == dpe_pkg::PORT_ETH1);
   assign eth2_out_valid = cur_valid && (cur_route == dpe_pkg::PORT_ETH2);

endmodule

`default_nettype wire

/* src/top.sv */
// Subsystem top level joining gpio, soc_csr and dpe on one clock
`default_nettype none
`include "wg_params.svh"

module top (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [1:0]            key_in,
   output logic [1:0]            led,
   input  logic                  csr_we,
   input  logic                  csr_re,
   input  csr_pkg::csr_addr_t    csr_addr,
   input  csr_pkg::csr_word_t    csr_wdata,
   output csr_pkg::csr_word_t    csr_rdata,
   output logic                  csr_rvalid,
   input  logic [`WG_DATA_W-1:0] cpu_in_data,
   input  logic                  cpu_in_valid,
   input  logic                  cpu_in_last,
   output logic                  cpu_in_ready,
   input  logic [`WG_DATA_W-1:0] eth1_in_data,
   input  logic                  eth1_in_valid,
   input  logic                  eth1_in_last,
   output logic                  eth1_in_ready,
   input  logic [`WG_DATA_W-1:0] eth2_in_data,
   input  logic                  eth2_in_valid,
   input  logic                  eth2_in_last,
   output logic                  eth2_in_ready,
   output logic [`WG_DATA_W-1:0] cpu_out_data,
   output logic                  cpu_out_valid,
   output logic                  cpu_out_last,
   input  logic                  cpu_out_ready,
   output logic [`WG_DATA_W-1:0] eth1_out_data,
   output logic                  eth1_out_valid,
   output logic                  eth1_out_last,
   input  logic                  eth1_out_ready,
   output logic [`WG_DATA_W-1:0] eth2_out_data,
   output logic                  eth2_out_valid,
   output logic                  eth2_out_last,
   input  logic                  eth2_out_ready
);
   logic [1:0]            key_state;
   logic [1:0]            led_value;
   logic                  dpe_enable;
   csr_pkg::route_table_t route_table;
   logic                  sent_pulse;
   dpe_pkg::route_t       sent_route;

   //====================
   // Keys and LEDs
   //====================
   gpio u_gpio (
      .clk       (clk),
      .rst       (rst),
      .key_in    (key_in),       // Pins
      .key_state (key_state),    // To CSR
      .led_value (led_value),    // From CSR
      .led       (led)           // Pins
   );

   //====================
   // Registers
   //====================
   soc_csr u_soc_csr (
      .clk         (clk),
      .rst         (rst),
      .csr_we      (csr_we),
      .csr_re      (csr_re),
      .csr_addr    (csr_addr),
      .csr_wdata   (csr_wdata),
      .csr_rdata   (csr_rdata),
      .csr_rvalid  (csr_rvalid),
      .key_state   (key_state),
      .led_value   (led_value),
      .dpe_enable  (dpe_enable),
      .route_table (route_table),
      .sent_pulse  (sent_pulse),   // Frame done, from dpe
      .sent_route  (sent_route)
   );

   //====================
   // Data plane
   //====================
   dpe u_dpe (
      .clk            (clk),
      .rst            (rst),
      .cpu_in_data    (cpu_in_data),
      .cpu_in_valid   (cpu_in_valid),
      .cpu_in_last    (cpu_in_last),
      .cpu_in_ready   (cpu_in_ready),
      .eth1_in_data   (eth1_in_data),
      .eth1_in_valid  (eth1_in_valid),
      .eth1_in_last   (eth1_in_last),
      .eth1_in_ready  (eth1_in_ready),
      .eth2_in_data   (eth2_in_data),
      .eth2_in_valid  (eth2_in_valid),
      .eth2_in_last   (eth2_in_last),
      .eth2_in_ready  (eth2_in_ready),
      .cpu_out_data   (cpu_out_data),
      .cpu_out_valid  (cpu_out_valid),
      .cpu_out_last   (cpu_out_last),
      .cpu_out_ready  (cpu_out_ready),
      .eth1_out_data  (eth1_out_data),
      .eth1_out_valid (eth1_out_valid),
      .eth1_out_last  (eth1_out_last),
      .eth1_out_ready (eth1_out_ready),
      .eth2_out_data  (eth2_out_data),
      .eth2_out_valid (eth2_out_valid),
      .eth2_out_last  (eth2_out_last),
      .eth2_out_ready (eth2_out_ready),
      .dpe_enable     (dpe_enable),
      .route_table    (route_table),
      .sent_pulse     (sent_pulse),
      .sent_route     (sent_route)
   );

endmodule

`default_nettype wire

/* tb/tb_top.sv */
// Pattern-driven testbench with frame drivers, output monitors and register checks
`default_nettype none
`include "wg_params.svh"

module tb_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_FRAMES = 64;
   localparam int MAX_LEN    = 16;
   localparam int WAIT_LIMIT = 3000;     // Cycles allowed per wait

   logic                            clk;
   logic                            rst;
   logic [1:0]                      key_in;
   wire  [1:0]                      led;
   logic                            csr_we;
   logic                            csr_re;
   csr_pkg::csr_addr_t              csr_addr;
   csr_pkg::csr_word_t              csr_wdata;
   wire  [`WG_CSR_DATA_W-1:0]       csr_rdata;
   wire                             csr_rvalid;
   logic [2:0][`WG_DATA_W-1:0]      in_data;    // Index 0 cpu, 1 eth1, 2 eth2
   logic [2:0]                      in_valid;
   logic [2:0]                      in_last;
   wire  [2:0]                      in_ready;
   wire  [2:0][`WG_DATA_W-1:0]      out_data;   // Index equals route code
   wire  [2:0]                      out_valid;
   wire  [2:0]                      out_last;
   logic [2:0]                      out_ready;

   logic [7:0] frm_byte [MAX_FRAMES][MAX_LEN];  // Expected frames
   int         frm_len  [MAX_FRAMES];
   int         frm_in   [MAX_FRAMES];
   int         frm_port [MAX_FRAMES];
   bit         frm_done [MAX_FRAMES];
   int         frm_cnt;
   int         drv_ptr  [3];                   // Next frame id per driver
   logic [7:0] rx_buf   [3][MAX_LEN];
   int         rx_len   [3];
   int         pulse_cnt;
   int         errors;
   int         tests_run;
   int         tests_failed;
   bit         aborted;
   int         seed;
   int         bp_seed;

   top dut (
      .clk (clk), .rst (rst), .key_in (key_in), .led (led),
      .csr_we (csr_we), .csr_re (csr_re), .csr_addr (csr_addr),
      .csr_wdata (csr_wdata), .csr_rdata (csr_rdata), .csr_rvalid (csr_rvalid),
      .cpu_in_data (in_data[0]), .cpu_in_valid (in_valid[0]),
      .cpu_in_last (in_last[0]), .cpu_in_ready (in_ready[0]),
      .eth1_in_data (in_data[1]), .eth1_in_valid (in_valid[1]),
      .eth1_in_last (in_last[1]), .eth1_in_ready (in_ready[1]),
      .eth2_in_data (in_data[2]), .eth2_in_valid (in_valid[2]),
      .eth2_in_last (in_last[2]), .eth2_in_ready (in_ready[2]),
      .cpu_out_data (out_data[0]), .cpu_out_valid (out_valid[0]),
      .cpu_out_last (out_last[0]), .cpu_out_ready (out_ready[0]),
      .eth1_out_data (out_data[1]), .eth1_out_valid (out_valid[1]),
      .eth1_out_last (out_last[1]), .eth1_out_ready (out_ready[1]),
      .eth2_out_data (out_data[2]), .eth2_out_valid (out_valid[2]),
      .eth2_out_last (out_last[2]), .eth2_out_ready (out_ready[2])
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;            // 40 ns period
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   function automatic bit all_sent();
      return drv_ptr[0] == frm_cnt && drv_ptr[1] == frm_cnt && drv_ptr[2] == frm_cnt;
   endfunction

   // ====================
   // Stream side
   // ====================
   task automatic send_frame(input int p, input int id);
      int t;
      for (int b = 0; b < frm_len[id]; b++) begin
         #2;
         in_data[p]  = frm_byte[id][b];
         in_last[p]  = (b == frm_len[id] - 1);
         in_valid[p] = 1'b1;
         t = 0;
         @(posedge clk);
         while (!in_ready[p] && t < WAIT_LIMIT) begin   // Held until accepted
            @(posedge clk);
            t++;
         end
         if (!in_ready[p]) begin
            $display("Input %0d never accepted beat %0d of frame %0d", p, b, id);
            aborted = 1'b1;
            return;
         end
      end
   endtask

   for (genvar g = 0; g < 3; g++) begin : g_drv
      initial begin
         forever begin
            @(posedge clk);
            while (drv_ptr[g] < frm_cnt) begin
               if (frm_in[drv_ptr[g]] == g) begin
                  send_frame(g, drv_ptr[g]);     // Back to back
               end
               drv_ptr[g]++;
            end
            #2;
            in_valid[g] = 1'b0;
         end
      end
   end

   // Random ready, high about three cycles in four
   initial begin
      int bp;
      out_ready = '1;
      forever begin
         @(posedge clk);
         #2;
         bp = $random(bp_seed);
         for (int p = 0; p < 3; p++) begin
            out_ready[p] = |bp[2*p +: 2];
         end
      end
   end

   task automatic match_frame(input int p);
      bit found;
      bit same;
      found = 1'b0;
      for (int id = 0; id < frm_cnt; id++) begin
         if (!found && !frm_done[id] && frm_port[id] == p && frm_len[id] == rx_len[p]) begin
            same = 1'b1;
            for (int b = 0; b < rx_len[p]; b++) begin
               if (frm_byte[id][b] !== rx_buf[p][b]) same = 1'b0;
            end
            if (same) begin
               frm_done[id] = 1'b1;
               found        = 1'b1;
            end
         end
      end
      if (!found) begin
         $display("Output %0d delivered a %0d-byte frame that no sent frame matches",
                  p, rx_len[p]);
         errors++;
      end
   endtask

   always @(posedge clk) begin
      for (int p = 0; p < 3; p++) begin
         if (!rst && out_valid[p] && out_ready[p]) begin
            if (rx_len[p] == MAX_LEN) begin
               $display("Output %0d frame runs past %0d bytes without last", p, MAX_LEN);
               errors++;
               rx_len[p] = 0;
            end
            rx_buf[p][rx_len[p]] = out_data[p];
            rx_len[p]++;
            if (out_last[p]) begin
               match_frame(p);
               rx_len[p] = 0;
            end
         end
      end
   end

   always @(posedge clk) begin
      if (rst) pulse_cnt = 0;
      else if (dut.sent_pulse) pulse_cnt++;   // Frames forwarded or dropped
   end

   // ====================
   // Pattern commands
   // ====================
   task automatic add_frame(input int src, input int hdr, input int len, input int port);
      if (frm_cnt == MAX_FRAMES || len < 1 || len > MAX_LEN || src > 2) begin
         $display("Frame command out of range for frame %0d", frm_cnt);
         aborted = 1'b1;
         return;
      end
      frm_byte[frm_cnt][0] = hdr[7:0];
      for (int b = 1; b < len; b++) begin
         frm_byte[frm_cnt][b] = 8'($random(seed));   // Payload
      end
      frm_len[frm_cnt]  = len;
      frm_in[frm_cnt]   = src;
      frm_port[frm_cnt] = port;
      frm_done[frm_cnt] = 1'b0;
      frm_cnt++;                                     // Publish to drivers last
   endtask

   task automatic wait_idle(input bit all_frames);
      int t;
      t = 0;
      @(negedge clk);
      while (!(all_sent() && (!all_frames || pulse_cnt == frm_cnt)) && t < WAIT_LIMIT) begin
         @(negedge clk);
         t++;
      end
      if (t == WAIT_LIMIT) begin
         $display("Frames still in flight after %0d cycles", WAIT_LIMIT);
         aborted = 1'b1;
      end
   endtask

   task automatic reg_write(input int addr, input int data);
      wait_idle(1'b0);                   // Headers already accepted keep old route
      @(posedge clk);
      #2;
      csr_we    = 1'b1;
      csr_addr  = csr_pkg::csr_addr_t'(addr);
      csr_wdata = csr_pkg::csr_word_t'(data);
      @(posedge clk);
      #2;
      csr_we = 1'b0;
      if (addr == csr_pkg::ADDR_CTRL) begin
         @(posedge clk);
         #2;
         check("led", led, ~data[2:1] & 2'b11);   // Active low pins
      end
   endtask

   task automatic reg_read(input int addr, input int exp);
      int t;
      wait_idle(1'b1);
      @(posedge clk);
      #2;
      csr_re   = 1'b1;
      csr_addr = csr_pkg::csr_addr_t'(addr);
      @(posedge clk);
      #2;
      csr_re = 1'b0;
      t = 0;
      while (!csr_rvalid && t < WAIT_LIMIT) begin
         @(posedge clk);
         #2;
         t++;
      end
      if (csr_rvalid) check($sformatf("csr_rdata[%0d]", addr), csr_rdata, exp);
      else begin
         $display("Read of address %0d never returned", addr);
         aborted = 1'b1;
      end
   endtask

   task automatic set_keys(input int pins, input int hold);
      @(posedge clk);
      #2;
      key_in = pins[1:0];
      repeat (hold) @(posedge clk);
   endtask

   task automatic close_test(input int id, input int err_before);
      if (id == 0) return;
      wait_idle(1'b1);
      tests_run++;
      if (errors == err_before && !aborted) $display("test %0d passed", id);
      else begin
         tests_failed++;
         $display("test %0d failed with %0d errors", id, errors - err_before);
      end
   endtask

   task automatic reject_line(input logic [7:0] cmd);
      $display("Pattern line for command '%c' has missing or bad fields", cmd);
      aborted = 1'b1;
   endtask

   task automatic run_patterns();
      int                fd;
      int                code;
      logic [7:0]        cmd;
      int                a, b, c, d;
      int                test_id;
      int                test_err;
      logic [8*160-1:0]  rest;
      test_id  = 0;
      test_err = 0;
      fd = $fopen("tb/dpe_patterns.txt", "r");
      if (fd == 0) begin
         $display("Cannot open tb/dpe_patterns.txt");
         aborted = 1'b1;
         return;
      end
      while (!aborted && $fscanf(fd, " %c", cmd) == 1) begin
         case (cmd)
            "#": code = $fgets(rest, fd);           // Comment line
            "T": begin
               code = $fscanf(fd, "%d", a);
               if (code != 1) reject_line(cmd);
               else begin
                  close_test(test_id, test_err);
                  test_id  = a;
                  test_err = errors;
               end
            end
            "W": begin
               code = $fscanf(fd, "%h %h", a, b);
               if (code != 2) reject_line(cmd);
               else reg_write(a, b);
            end
            "R": begin
               code = $fscanf(fd, "%h %h", a, b);
               if (code != 2) reject_line(cmd);
               else reg_read(a, b);
            end
            "F": begin
               code = $fscanf(fd, "%d %h %d %d", a, b, c, d);
               if (code != 4) reject_line(cmd);
               else add_frame(a, b, c, d);
            end
            "K": begin
               code = $fscanf(fd, "%h %d", a, b);
               if (code != 2) reject_line(cmd);
               else set_keys(a, b);
            end
            default: begin
               $display("Unknown pattern command '%c'", cmd);
               aborted = 1'b1;
            end
         endcase
      end
      if (!aborted) close_test(test_id, test_err);
      $fclose(fd);
   endtask

   // ====================
   // Main sequence
   // ====================
   initial begin
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      aborted      = 1'b0;
      seed         = 5;
      bp_seed      = 5;
      frm_cnt      = 0;
      pulse_cnt    = 0;
      for (int p = 0; p < 3; p++) begin
         drv_ptr[p] = 0;
         rx_len[p]  = 0;
      end
      rst       = 1'b1;
      key_in    = 2'b11;                 // Keys released
      csr_we    = 1'b0;
      csr_re    = 1'b0;
      csr_addr  = '0;
      csr_wdata = '0;
      in_data   = '0;
      in_valid  = '0;
      in_last   = '0;
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
      check("led", led, 2'b11);          // Off after reset
      run_patterns();
      for (int i = 0; i < frm_cnt; i++) begin
         if (!aborted && frm_port[i] != 3 && !frm_done[i]) begin
            $display("Frame %0d never arrived at output %0d", i, frm_port[i]);
            errors++;
         end
      end
      $display("%0d tests run, %0d tests failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0 && !aborted) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/dpe_pkg.sv
common/csr_pkg.sv
src/stream_fifo.sv
src/gpio.sv
csr/soc_csr.sv
dpe/dpe.sv
src/top.sv
tb/tb_top.sv

/* tb/dpe_patterns.txt */
# cmd: T test | W addr data | R addr expected | K key_pins hold_cycles
# cmd: F in_port header_hex length expected_port (3 means dropped, never seen)
T 1
R 0 0000
R 1 0000
R 2 0000
R 3 0000
R 4 0000
R 5 0000
R 6 0000
F 0 A4 4 3
R 6 0001
R 3 0000
T 2
W 0 0006
R 0 0006
W 0 0002
R 0 0002
T 3
W 1 00E4
W 0 0001
R 1 00E4
F 0 11 5 1
F 1 22 3 2
F 2 30 6 0
F 2 13 2 3
R 3 0001
R 4 0001
R 5 0001
R 6 0002
T 4
F 0 01 4 1
F 1 02 7 2
F 2 00 3 0
F 0 02 5 2
F 1 01 1 1
F 2 01 6 1
F 0 00 8 0
F 1 03 4 3
F 2 02 5 2
R 3 0003
R 4 0004
R 5 0004
R 6 0003
T 5
F 0 05 6 1
F 1 09 6 1
F 2 0D 6 1
W 1 00E8
F 0 15 3 2
F 1 19 3 2
R 4 0007
R 5 0006
T 6
K 2 20
R 2 0001
K 3 20
R 2 0000
K 1 3
K 3 4
R 2 0000
